//--- control_unit.f
+incdir+design
design/cpu_ctrl_pkg.sv
design/instr_decoder.sv
design/ctrl_sequencer.sv
design/ctrl_word_gen.sv
design/control_unit.sv
tests/control_unit_chk.sv
tests/control_unit_tb.sv

//--- tests/control_unit_tb.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module control_unit_tb;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_INSTR    = 22;
    localparam int MAX_CYCLES = 20; // Longest instruction is 12
    localparam alu_flags_t NO_FLAGS = '0;
    localparam alu_flags_t OV_HIGH  = '{ov: 1'b1, lt: 1'b0};
    localparam alu_flags_t LT_HIGH  = '{ov: 1'b0, lt: 1'b1};

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    funct_t     funct;
    alu_flags_t flags;
    ctrl_word_t ctrl;

    int         cycles;      // ir_write to ir_write
    alu_op_t    exe_op;      // ALU op of the execute step
    ctrl_word_t seen;        // Fields taken from the write pulses
    int         n_checks;
    int         n_value_err;
    int         n_other_err;

    control_unit i_dut (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((N_INSTR * 12 + 50) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", N_INSTR * 12 + 50);
        $display("Test failures found");
        $finish;
    end

    task automatic check_word(input string what, input ctrl_word_t got, input ctrl_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAIL %0t: %s word %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_value_err++;
            $display("FAIL %0t: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_class_fields(input string what, input alu_op_t op,
                                      input pc_src_t pcs, input wb_src_t wb);
        n_checks++;
        if (exe_op !== op || seen.pc_src !== pcs || seen.mem_to_reg !== wb) begin
            n_value_err++;
            $display("FAIL %0t: %s alu_op/pc_src/mem_to_reg %b/%b/%b, expected %b/%b/%b",
                     $time, what, exe_op, seen.pc_src, seen.mem_to_reg, op, pcs, wb);
        end
    endtask

    function automatic ctrl_word_t reg_sum(input reg_dst_t dst, input wb_src_t wb);
        ctrl_word_t w;
        w            = '0;
        w.reg_write  = 1'b1;
        w.reg_dst    = dst;
        w.mem_to_reg = wb;
        return w;
    endfunction

    function automatic ctrl_word_t mem_sum(input logic load, input mem_width_t width);
        ctrl_word_t w;
        w = '0;
        if (load) begin // MDR fill then write-back to rt
            w            = reg_sum(`CTRL_DST_RT, `CTRL_WB_MDR);
            w.mdr_write  = 1'b1;
            w.mem_to_mdr = width;
        end else begin
            w.mem_wr = 1'b1;
            w.b_to_c = width;
        end
        return w;
    endfunction

    function automatic ctrl_word_t pc_sum(input pc_src_t pcs, input logic br);
        ctrl_word_t w;
        w          = '0;
        w.pc_write = 1'b1;
        w.pc_src   = pcs;
        w.branch   = br;
        return w;
    endfunction

    function automatic ctrl_word_t exc_sum(input exc_cause_t cause);
        ctrl_word_t w;
        w              = pc_sum(`CTRL_PC_EXC, 1'b0);
        w.epc_write    = 1'b1;
        w.except_cause = cause;
        return w;
    endfunction

    // Address from PC, PC + 4 prepared, strobes only in the fetch cycle
    function automatic ctrl_word_t fetch_word(input logic strobe);
        ctrl_word_t w;
        w           = '0;
        w.i_or_d    = `CTRL_IOD_PC;
        w.alu_src_a = `CTRL_SRCA_PC;
        w.alu_src_b = `CTRL_SRCB_FOUR;
        w.alu_op    = `CTRL_ALU_ADD;
        w.pc_src    = `CTRL_PC_ALU;
        w.pc_write  = strobe;
        w.ir_write  = strobe;
        return w;
    endfunction

    function automatic ctrl_word_t decode_word();
        ctrl_word_t w;
        w         = '0;
        w.a_write = 1'b1;
        w.b_write = 1'b1;
        return w;
    endfunction

    // Starts on the negedge where this instruction's ir_write is visible
    task automatic run_instr(input opcode_t op, input funct_t fn, input alu_flags_t fl);
        ctrl_word_t w;
        ctrl_word_t prev_w;      // Last fetch-wait word
        ctrl_word_t dec_w;
        logic       exe_seen;
        int         n_pulses;
        opcode   = op;
        funct    = fn;
        flags    = fl;
        cycles   = 0;
        seen     = '0;
        exe_op   = `CTRL_ALU_PASS;
        exe_seen = 1'b0;
        n_pulses = 0;
        w        = '0;
        prev_w   = '0;
        dec_w    = '0;
        do begin
            @(negedge clk);
            cycles++;
            prev_w = w;
            w      = ctrl;
            if (cycles == 1)
                dec_w = w;
            if (!w.ir_write) begin
                if (!exe_seen && (w.alu_reg_write || w.alu_op == `CTRL_ALU_SLT)) begin
                    exe_op   = w.alu_op;
                    exe_seen = 1'b1;
                end
                if (w.reg_write) begin
                    n_pulses++;
                    seen.reg_write  = 1'b1;
                    seen.reg_dst    = w.reg_dst;
                    seen.mem_to_reg = w.mem_to_reg;
                end
                if (w.mem_wr) begin
                    n_pulses++;
                    seen.mem_wr = 1'b1;
                    seen.b_to_c = w.b_to_c;
                end
                if (w.mdr_write) begin
                    seen.mdr_write  = 1'b1;
                    seen.mem_to_mdr = w.mem_to_mdr;
                end
                if (w.pc_write) begin
                    seen.pc_write = 1'b1;
                    seen.pc_src   = w.pc_src;
                    seen.branch   = w.branch;
                end
                if (w.epc_write) begin
                    n_pulses++;
                    seen.epc_write    = 1'b1;
                    seen.except_cause = w.except_cause;
                end
            end
        end while (!w.ir_write && cycles < MAX_CYCLES);
        if (!w.ir_write) begin
            n_other_err++;
            $display("%0t: no instruction fetch within %0d cycles", $time, MAX_CYCLES);
        end else begin
            check_word($sformatf("opcode %h decode", op), dec_w, decode_word());
            check_word($sformatf("opcode %h fetch wait", op), prev_w, fetch_word(1'b0));
            check_word($sformatf("opcode %h fetch", op), w, fetch_word(1'b1));
        end
        if (n_pulses > 1) begin // JAL links through reg_write only
            n_other_err++;
            $display("%0t: opcode %h gave %0d write pulses instead of one", $time, op, n_pulses);
        end
    endtask

    task automatic check_instr(input string name, input int exp_cycles, input alu_op_t op,
                               input pc_src_t pcs, input ctrl_word_t exp_seen);
        check_cycles(name, cycles, exp_cycles);
        check_class_fields(name, op, pcs, exp_seen.mem_to_reg);
        check_word(name, seen, exp_seen);
    endtask

    task automatic reset_test();
        ctrl_word_t init_w;
        int         n_init;
        reset = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_word("ctrl in reset", ctrl, '0);
        end
        reset  = 1'b0;
        n_init = 0;
        init_w = '0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (ctrl.reg_write) begin
                n_init++;
                init_w = ctrl;
            end
        end while (!ctrl.ir_write && cycles < MAX_CYCLES);
        check_cycles("stack init words", n_init, 1);
        check_word("stack init", init_w, reg_sum(`CTRL_DST_STACK, `CTRL_WB_STACK));
    endtask

    task automatic alu_test();
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_ADD, NO_FLAGS);
        check_instr("add", 9, `CTRL_ALU_ADD, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RD, `CTRL_WB_ALU));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_SUB, NO_FLAGS);
        check_instr("sub", 9, `CTRL_ALU_SUB, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RD, `CTRL_WB_ALU));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_AND, NO_FLAGS);
        check_instr("and", 9, `CTRL_ALU_AND, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RD, `CTRL_WB_ALU));
        run_instr(`CTRL_OP_ADDI, '0, NO_FLAGS);
        check_instr("addi", 9, `CTRL_ALU_ADD, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RT, `CTRL_WB_ALU));
        run_instr(`CTRL_OP_ADDIU, '0, OV_HIGH); // Unsigned ignores ov
        check_instr("addiu", 8, `CTRL_ALU_ADD, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RT, `CTRL_WB_ALU));
        run_instr(`CTRL_OP_LUI, '0, NO_FLAGS);
        check_instr("lui", 7, `CTRL_ALU_PASS, `CTRL_PC_ALU,
                    reg_sum(`CTRL_DST_RT, `CTRL_WB_UPPER));
    endtask

    task automatic overflow_test();
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_ADD, OV_HIGH);
        check_instr("add overflow", 12, `CTRL_ALU_ADD, `CTRL_PC_EXC,
                    exc_sum(`CTRL_EXC_OVERFLOW));
        run_instr(6'h3f, '0, NO_FLAGS);
        check_instr("illegal opcode", 10, `CTRL_ALU_PASS, `CTRL_PC_EXC,
                    exc_sum(`CTRL_EXC_OPCODE));
    endtask

    task automatic load_test();
        run_instr(`CTRL_OP_LW, '0, NO_FLAGS);
        check_instr("lw", 12, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b1, `CTRL_MEM_WORD));
        run_instr(`CTRL_OP_LH, '0, NO_FLAGS);
        check_instr("lh", 12, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b1, `CTRL_MEM_HALF));
        run_instr(`CTRL_OP_LB, '0, NO_FLAGS);
        check_instr("lb", 12, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b1, `CTRL_MEM_BYTE));
    endtask

    task automatic store_test();
        run_instr(`CTRL_OP_SW, '0, NO_FLAGS);
        check_instr("sw", 8, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b0, `CTRL_MEM_WORD));
        run_instr(`CTRL_OP_SH, '0, NO_FLAGS);
        check_instr("sh", 11, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b0, `CTRL_MEM_HALF));
        run_instr(`CTRL_OP_SB, '0, NO_FLAGS);
        check_instr("sb", 11, `CTRL_ALU_ADD, `CTRL_PC_ALU, mem_sum(1'b0, `CTRL_MEM_BYTE));
    endtask

    task automatic jump_slt_test();
        run_instr(`CTRL_OP_J, '0, NO_FLAGS);
        check_instr("j", 7, `CTRL_ALU_PASS, `CTRL_PC_JUMP, pc_sum(`CTRL_PC_JUMP, 1'b1));
        run_instr(`CTRL_OP_JAL, '0, NO_FLAGS);
        check_instr("jal", 8, `CTRL_ALU_PASS, `CTRL_PC_JUMP,
                    ctrl_word_t'(reg_sum(`CTRL_DST_RA, `CTRL_WB_ALU) |
                                 pc_sum(`CTRL_PC_JUMP, 1'b1)));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_JR, NO_FLAGS);
        check_instr("jr", 7, `CTRL_ALU_PASS, `CTRL_PC_ALU, pc_sum(`CTRL_PC_ALU, 1'b1));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_RTE, NO_FLAGS);
        check_instr("rte", 7, `CTRL_ALU_PASS, `CTRL_PC_EPC, pc_sum(`CTRL_PC_EPC, 1'b0));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_SLT, LT_HIGH);
        check_instr("slt set", 8, `CTRL_ALU_SLT, `CTRL_PC_ALU, reg_sum(`CTRL_DST_RD, `CTRL_WB_ONE));
        run_instr(`CTRL_OP_RTYPE, `CTRL_FN_SLT, NO_FLAGS);
        check_instr("slt clear", 8, `CTRL_ALU_SLT, `CTRL_PC_ALU,
                    reg_sum(`CTRL_DST_RD, `CTRL_WB_ZERO));
        run_instr(`CTRL_OP_SLTI, '0, LT_HIGH);
        check_instr("slti set", 8, `CTRL_ALU_SLT, `CTRL_PC_ALU,
                    reg_sum(`CTRL_DST_RT, `CTRL_WB_ONE));
        run_instr(`CTRL_OP_SLTI, '0, NO_FLAGS);
        check_instr("slti clear", 8, `CTRL_ALU_SLT, `CTRL_PC_ALU,
                    reg_sum(`CTRL_DST_RT, `CTRL_WB_ZERO));
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        opcode      = '0;
        funct       = '0;
        flags       = NO_FLAGS;
        n_checks    = 0;
        n_value_err = 0;
        n_other_err = 0;
        reset_test();
        alu_test();
        overflow_test();
        load_test();
        store_test();
        jump_slt_test();
        $display("Checks: %0d  value errors: %0d  other errors: %0d",
                 n_checks, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- tests/control_unit_chk.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module control_unit_chk (
    input logic                     clk,
    input logic                     reset,
    input cpu_ctrl_pkg::ctrl_word_t ctrl
);
    import cpu_ctrl_pkg::*;

    // Word register still clear in the first cycle out of reset
    zero_after_reset: assert property (@(posedge clk) $fell(reset) |-> ctrl == '0)
        else $error("ctrl not zero in the cycle after reset");

    ir_write_single: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |=> !ctrl.ir_write)
        else $error("ir_write held for more than one cycle");

    no_store_and_write: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_wr && ctrl.reg_write))
        else $error("mem_wr and reg_write high together");

    epc_with_vector: assert property (@(posedge clk) disable iff (reset)
        ctrl.epc_write |-> (ctrl.pc_write && ctrl.pc_src == `CTRL_PC_EXC))
        else $error("epc_write without a jump to the exception vector");

endmodule

bind control_unit control_unit_chk i_chk (.clk(clk), .reset(reset), .ctrl(ctrl));

//--- design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_ctrl_pkg::opcode_t    opcode,
    input  cpu_ctrl_pkg::funct_t     funct,
    input  cpu_ctrl_pkg::alu_flags_t flags,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);
    import cpu_ctrl_pkg::*;

    instr_class_e instr_class;
    ctrl_state_e  state;

    // Sampled by the sequencer in dispatch
    instr_decoder i_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    ctrl_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .flags       (flags),
        .state       (state)
    );

    ctrl_word_gen i_word_gen (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .ctrl  (ctrl)   // One cycle behind state
    );

endmodule

//--- design/ctrl_word_gen.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module ctrl_word_gen (
    input  logic                      clk,
    input  logic                      reset,
    input  cpu_ctrl_pkg::ctrl_state_e state,
    output cpu_ctrl_pkg::ctrl_word_t  ctrl
);
    import cpu_ctrl_pkg::*;

    ctrl_word_t ctrl_nxt;

    always_comb begin
        ctrl_nxt = '0;
        case (state)
            ST_INIT: begin // Clear the register stack top
                ctrl_nxt.reg_write  = 1'b1;
                ctrl_nxt.reg_dst    = `CTRL_DST_STACK;
                ctrl_nxt.mem_to_reg = `CTRL_WB_STACK;
            end
            ST_FETCH_WAIT, ST_FETCH: begin
                ctrl_nxt.i_or_d    = `CTRL_IOD_PC;
                ctrl_nxt.alu_src_a = `CTRL_SRCA_PC;
                ctrl_nxt.alu_src_b = `CTRL_SRCB_FOUR; // PC + 4
                ctrl_nxt.alu_op    = `CTRL_ALU_ADD;
                ctrl_nxt.pc_src    = `CTRL_PC_ALU;
                ctrl_nxt.pc_write  = (state == ST_FETCH);
                ctrl_nxt.ir_write  = (state == ST_FETCH);
            end
            ST_DECODE: begin
                ctrl_nxt.a_write = 1'b1;
                ctrl_nxt.b_write = 1'b1;
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_ADDI, ST_ALU_ADDIU, ST_MEM_ADDR: begin
                ctrl_nxt.alu_src_a     = `CTRL_SRCA_A;
                ctrl_nxt.alu_reg_write = 1'b1;
                ctrl_nxt.alu_src_b     = (state inside {ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND}) ?
                                         `CTRL_SRCB_B : `CTRL_SRCB_IMM;
                ctrl_nxt.alu_op        = (state == ST_ALU_SUB) ? `CTRL_ALU_SUB :
                                         (state == ST_ALU_AND) ? `CTRL_ALU_AND : `CTRL_ALU_ADD;
            end
            ST_WB_RD, ST_WB_RT: begin
                ctrl_nxt.reg_write  = 1'b1;
                ctrl_nxt.reg_dst    = (state == ST_WB_RD) ? `CTRL_DST_RD : `CTRL_DST_RT;
                ctrl_nxt.mem_to_reg = `CTRL_WB_ALU;
            end
            ST_LUI: begin
                ctrl_nxt.reg_write  = 1'b1;
                ctrl_nxt.reg_dst    = `CTRL_DST_RT;
                ctrl_nxt.mem_to_reg = `CTRL_WB_UPPER;
            end
            ST_SLT_CMP, ST_SLTI_CMP: begin
                ctrl_nxt.alu_src_a = `CTRL_SRCA_A;
                ctrl_nxt.alu_src_b = (state == ST_SLT_CMP) ? `CTRL_SRCB_B : `CTRL_SRCB_IMM;
                ctrl_nxt.alu_op    = `CTRL_ALU_SLT;
            end
            ST_SET_RD, ST_CLR_RD, ST_SET_RT, ST_CLR_RT: begin
                ctrl_nxt.reg_write  = 1'b1;
                ctrl_nxt.reg_dst    = (state inside {ST_SET_RD, ST_CLR_RD}) ?
                                      `CTRL_DST_RD : `CTRL_DST_RT;
                ctrl_nxt.mem_to_reg = (state inside {ST_SET_RD, ST_SET_RT}) ?
                                      `CTRL_WB_ONE : `CTRL_WB_ZERO;
            end
            ST_MEM_WAIT: ctrl_nxt.i_or_d = `CTRL_IOD_ALU;
            ST_MDR_W, ST_MDR_H, ST_MDR_B: begin
                ctrl_nxt.i_or_d     = `CTRL_IOD_ALU;
                ctrl_nxt.mdr_write  = 1'b1;
                ctrl_nxt.mem_to_mdr = (state == ST_MDR_W) ? `CTRL_MEM_WORD :
                                      (state == ST_MDR_H) ? `CTRL_MEM_HALF : `CTRL_MEM_BYTE;
            end
            ST_WB_MDR: begin
                ctrl_nxt.reg_write  = 1'b1;
                ctrl_nxt.reg_dst    = `CTRL_DST_RT;
                ctrl_nxt.mem_to_reg = `CTRL_WB_MDR;
            end
            ST_STORE_W, ST_STORE_H, ST_STORE_B: begin
                ctrl_nxt.i_or_d = `CTRL_IOD_ALU;
                ctrl_nxt.mem_wr = 1'b1;
                ctrl_nxt.b_to_c = (state == ST_STORE_W) ? `CTRL_MEM_WORD :
                                  (state == ST_STORE_H) ? `CTRL_MEM_HALF : `CTRL_MEM_BYTE;
            end
            ST_JUMP, ST_JAL_STORE: begin
                ctrl_nxt.pc_write = 1'b1;
                ctrl_nxt.branch   = 1'b1;
                ctrl_nxt.pc_src   = `CTRL_PC_JUMP;
                if (state == ST_JAL_STORE) begin // Link into ra
                    ctrl_nxt.reg_write  = 1'b1;
                    ctrl_nxt.reg_dst    = `CTRL_DST_RA;
                    ctrl_nxt.mem_to_reg = `CTRL_WB_ALU;
                end
            end
            ST_JAL_LINK: begin
                ctrl_nxt.alu_src_a     = `CTRL_SRCA_PC;
                ctrl_nxt.alu_op        = `CTRL_ALU_PASS;
                ctrl_nxt.alu_reg_write = 1'b1;
            end
            ST_JR: begin
                ctrl_nxt.alu_src_a = `CTRL_SRCA_A;
                ctrl_nxt.alu_op    = `CTRL_ALU_PASS;
                ctrl_nxt.pc_src    = `CTRL_PC_ALU;
                ctrl_nxt.branch    = 1'b1;
                ctrl_nxt.pc_write  = 1'b1;
            end
            ST_RTE: begin
                ctrl_nxt.pc_src   = `CTRL_PC_EPC;
                ctrl_nxt.pc_write = 1'b1;
            end
            ST_EXC_WAIT_OP, ST_EXC_WAIT_OV: begin
                ctrl_nxt.i_or_d       = `CTRL_IOD_EXC; // Read handler vector
                ctrl_nxt.alu_src_a    = `CTRL_SRCA_PC;
                ctrl_nxt.alu_src_b    = `CTRL_SRCB_FOUR;
                ctrl_nxt.alu_op       = `CTRL_ALU_SUB; // Faulting PC into EPC
                ctrl_nxt.except_cause = (state == ST_EXC_WAIT_OV) ?
                                        `CTRL_EXC_OVERFLOW : `CTRL_EXC_OPCODE;
            end
            ST_EXC_OP, ST_EXC_OV: begin
                ctrl_nxt.epc_write    = 1'b1;
                ctrl_nxt.pc_write     = 1'b1;
                ctrl_nxt.pc_src       = `CTRL_PC_EXC;
                ctrl_nxt.except_cause = (state == ST_EXC_OV) ?
                                        `CTRL_EXC_OVERFLOW : `CTRL_EXC_OPCODE;
            end
            default: ctrl_nxt = '0; // Dispatch and overflow check drive nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            ctrl <= '0;
        else
            ctrl <= ctrl_nxt;
    end

endmodule

//--- design/ctrl_sequencer.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module ctrl_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_ctrl_pkg::instr_class_e instr_class,
    input  cpu_ctrl_pkg::alu_flags_t   flags,
    output cpu_ctrl_pkg::ctrl_state_e  state
);
    import cpu_ctrl_pkg::*;

    ctrl_state_e  state_nxt;
    instr_class_e cls_q;
    wait_cnt_t    wait_cnt;
    wait_cnt_t    wait_len;
    logic         wait_done;

    // Zero length outside the wait states
    always_comb begin
        case (state)
            ST_FETCH_WAIT:                  wait_len = wait_cnt_t'(`CTRL_FETCH_WAIT);
            ST_MEM_WAIT:                    wait_len = wait_cnt_t'(`CTRL_MEM_WAIT);
            ST_EXC_WAIT_OP, ST_EXC_WAIT_OV: wait_len = wait_cnt_t'(`CTRL_EXC_WAIT);
            default:                        wait_len = '0;
        endcase
    end

    assign wait_done = (wait_cnt == wait_len - 1'b1);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT:       state_nxt = ST_FETCH_WAIT;
            ST_FETCH_WAIT: if (wait_done) state_nxt = ST_FETCH;
            ST_FETCH:      state_nxt = ST_DECODE;
            ST_DECODE:     state_nxt = ST_DISPATCH;
            ST_DISPATCH: begin
                case (instr_class)
                    ADD:                        state_nxt = ST_ALU_ADD;
                    SUB:                        state_nxt = ST_ALU_SUB;
                    AND:                        state_nxt = ST_ALU_AND;
                    ADDI:                       state_nxt = ST_ALU_ADDI;
                    ADDIU:                      state_nxt = ST_ALU_ADDIU;
                    LUI:                        state_nxt = ST_LUI;
                    SLT:                        state_nxt = ST_SLT_CMP;
                    SLTI:                       state_nxt = ST_SLTI_CMP;
                    LW, LH, LB, SW, SH, SB:     state_nxt = ST_MEM_ADDR;
                    J:                          state_nxt = ST_JUMP;
                    JAL:                        state_nxt = ST_JAL_LINK;
                    JR:                         state_nxt = ST_JR;
                    RTE:                        state_nxt = ST_RTE;
                    default:                    state_nxt = ST_EXC_WAIT_OP;
                endcase
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_ADDI: state_nxt = ST_OV_CHECK;
            ST_ALU_ADDIU: state_nxt = ST_WB_RT;
            ST_OV_CHECK: begin // Only place ov is looked at
                if (flags.ov)
                    state_nxt = ST_EXC_WAIT_OV;
                else if (cls_q == ADDI)
                    state_nxt = ST_WB_RT;
                else
                    state_nxt = ST_WB_RD;
            end
            ST_SLT_CMP, ST_SLTI_CMP: begin
                if (flags.lt) begin
                    if (cls_q == SLTI)
                        state_nxt = ST_SET_RT;
                    else
                        state_nxt = ST_SET_RD;
                end else begin
                    if (cls_q == SLTI)
                        state_nxt = ST_CLR_RT;
                    else
                        state_nxt = ST_CLR_RD;
                end
            end
            ST_MEM_ADDR: begin
                if (cls_q == SW)
                    state_nxt = ST_STORE_W; // Full word needs no read
                else
                    state_nxt = ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                if (wait_done) begin
                    case (cls_q)
                        LW:      state_nxt = ST_MDR_W;
                        LH:      state_nxt = ST_MDR_H;
                        LB:      state_nxt = ST_MDR_B;
                        SH:      state_nxt = ST_STORE_H;
                        default: state_nxt = ST_STORE_B;
                    endcase
                end
            end
            ST_MDR_W, ST_MDR_H, ST_MDR_B: state_nxt = ST_WB_MDR;
            ST_JAL_LINK:    state_nxt = ST_JAL_STORE;
            ST_EXC_WAIT_OP: if (wait_done) state_nxt = ST_EXC_OP;
            ST_EXC_WAIT_OV: if (wait_done) state_nxt = ST_EXC_OV;
            default:        state_nxt = ST_FETCH_WAIT; // Last step of an instruction
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_INIT;
            wait_cnt <= '0;
            cls_q    <= ILLEGAL;
        end else begin
            state <= state_nxt;
            if (wait_done || wait_len == '0)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;
            if (state == ST_DISPATCH)
                cls_q <= instr_class;
        end
    end

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module instr_decoder (
    input  cpu_ctrl_pkg::opcode_t      opcode,
    input  cpu_ctrl_pkg::funct_t       funct,
    output cpu_ctrl_pkg::instr_class_e instr_class
);
    import cpu_ctrl_pkg::*;

    instr_class_e rtype_class;

    // Only meaningful when opcode is R-type
    always_comb begin
        case (funct)
            `CTRL_FN_ADD: rtype_class = ADD;
            `CTRL_FN_SUB: rtype_class = SUB;
            `CTRL_FN_AND: rtype_class = AND;
            `CTRL_FN_SLT: rtype_class = SLT;
            `CTRL_FN_JR:  rtype_class = JR;
            `CTRL_FN_RTE: rtype_class = RTE;
            default:      rtype_class = ILLEGAL;
        endcase
    end

    always_comb begin
        case (opcode)
            `CTRL_OP_RTYPE: instr_class = rtype_class;
            `CTRL_OP_ADDI:  instr_class = ADDI;
            `CTRL_OP_ADDIU: instr_class = ADDIU;
            `CTRL_OP_LUI:   instr_class = LUI;
            `CTRL_OP_SLTI:  instr_class = SLTI;
            `CTRL_OP_LW:    instr_class = LW;
            `CTRL_OP_LH:    instr_class = LH;
            `CTRL_OP_LB:    instr_class = LB;
            `CTRL_OP_SW:    instr_class = SW;
            `CTRL_OP_SH:    instr_class = SH;
            `CTRL_OP_SB:    instr_class = SB;
            `CTRL_OP_J:     instr_class = J;
            `CTRL_OP_JAL:   instr_class = JAL;
            default:        instr_class = ILLEGAL; // Raises opcode exception
        endcase
    end

endmodule

//--- design/cpu_ctrl_pkg.sv
`include "cpu_ctrl_config.svh"

package cpu_ctrl_pkg;

    typedef logic [`CTRL_OPCODE_W-1:0] opcode_t;
    typedef logic [`CTRL_FUNCT_W-1:0]  funct_t;

    typedef logic [2:0] alu_op_t;
    typedef logic [2:0] pc_src_t;
    typedef logic [1:0] reg_dst_t;
    typedef logic [1:0] mem_width_t;
    typedef logic [1:0] exc_cause_t;
    typedef logic [3:0] wb_src_t;
    typedef logic [2:0] i_or_d_t;
    typedef logic [2:0] alu_src_b_t;
    typedef logic [1:0] alu_src_a_t;

    typedef logic [`CTRL_WAIT_W-1:0] wait_cnt_t;

    typedef enum logic [4:0] {
        ADD, SUB, AND, ADDI, ADDIU, LUI, SLT, SLTI,
        LW, LH, LB, SW, SH, SB,
        J, JAL, JR, RTE,
        ILLEGAL
    } instr_class_e;

    typedef enum logic [6:0] {
        ST_INIT, ST_FETCH_WAIT, ST_FETCH, ST_DECODE, ST_DISPATCH,
        ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_ADDI, ST_ALU_ADDIU,
        ST_OV_CHECK, ST_WB_RD, ST_WB_RT, ST_LUI,
        ST_SLT_CMP, ST_SLTI_CMP, ST_SET_RD, ST_CLR_RD, ST_SET_RT, ST_CLR_RT,
        ST_MEM_ADDR, ST_MEM_WAIT, ST_MDR_W, ST_MDR_H, ST_MDR_B, ST_WB_MDR,
        ST_STORE_W, ST_STORE_H, ST_STORE_B,
        ST_JUMP, ST_JAL_LINK, ST_JAL_STORE, ST_JR, ST_RTE,
        ST_EXC_WAIT_OP, ST_EXC_WAIT_OV, ST_EXC_OP, ST_EXC_OV
    } ctrl_state_e;

    typedef struct packed {
        logic ov;
        logic lt;
    } alu_flags_t;

    typedef struct packed {
        logic       pc_write;
        logic       branch;
        logic       mem_wr;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       mdr_write;
        logic       alu_reg_write;
        logic       epc_write;
        logic       reg_write;
        exc_cause_t except_cause;
        mem_width_t mem_to_mdr;
        mem_width_t b_to_c;
        alu_src_a_t alu_src_a;
        reg_dst_t   reg_dst;
        i_or_d_t    i_or_d;
        alu_src_b_t alu_src_b;
        alu_op_t    alu_op;
        pc_src_t    pc_src;
        wb_src_t    mem_to_reg;
    } ctrl_word_t;

endpackage

//--- design/cpu_ctrl_config.svh
`ifndef CPU_CTRL_CONFIG_SVH
`define CPU_CTRL_CONFIG_SVH

// Field and counter widths
`define CTRL_OPCODE_W 6
`define CTRL_FUNCT_W  6
`define CTRL_WAIT_W   3

// Opcodes
`define CTRL_OP_RTYPE 6'h00
`define CTRL_OP_ADDI  6'h08
`define CTRL_OP_ADDIU 6'h09
`define CTRL_OP_LUI   6'h0f
`define CTRL_OP_SLTI  6'h0a
`define CTRL_OP_LW    6'h23
`define CTRL_OP_LH    6'h21
`define CTRL_OP_LB    6'h20
`define CTRL_OP_SW    6'h2b
`define CTRL_OP_SH    6'h29
`define CTRL_OP_SB    6'h28
`define CTRL_OP_J     6'h02
`define CTRL_OP_JAL   6'h03

// R-type funct codes
`define CTRL_FN_ADD 6'h20
`define CTRL_FN_SUB 6'h22
`define CTRL_FN_AND 6'h24
`define CTRL_FN_SLT 6'h2a
`define CTRL_FN_JR  6'h08
`define CTRL_FN_RTE 6'h13

`define CTRL_ALU_PASS 3'b000
`define CTRL_ALU_ADD  3'b001
`define CTRL_ALU_SUB  3'b010
`define CTRL_ALU_AND  3'b011
`define CTRL_ALU_SLT  3'b111

`define CTRL_PC_ALU  3'b000
`define CTRL_PC_JUMP 3'b010
`define CTRL_PC_EXC  3'b011
`define CTRL_PC_EPC  3'b100

`define CTRL_DST_RT    2'b00
`define CTRL_DST_RD    2'b01
`define CTRL_DST_STACK 2'b10
`define CTRL_DST_RA    2'b11

`define CTRL_WB_ALU   4'b0000
`define CTRL_WB_MDR   4'b0001
`define CTRL_WB_STACK 4'b0100
`define CTRL_WB_ZERO  4'b0101
`define CTRL_WB_ONE   4'b0110
`define CTRL_WB_UPPER 4'b1000

// Load and store widths
`define CTRL_MEM_WORD 2'b00
`define CTRL_MEM_HALF 2'b01
`define CTRL_MEM_BYTE 2'b10

`define CTRL_EXC_OPCODE   2'b00
`define CTRL_EXC_OVERFLOW 2'b01

// Memory address and ALU operand selects
`define CTRL_IOD_PC    3'b000
`define CTRL_IOD_ALU   3'b001
`define CTRL_IOD_EXC   3'b010
`define CTRL_SRCA_PC   2'b00
`define CTRL_SRCA_A    2'b01
`define CTRL_SRCB_B    3'b000
`define CTRL_SRCB_FOUR 3'b001
`define CTRL_SRCB_IMM  3'b010

// Wait lengths in cycles
`define CTRL_FETCH_WAIT 3
`define CTRL_MEM_WAIT   3
`define CTRL_EXC_WAIT   3

`endif
